// ==== src/mem_tile_defs.svh ====
/*
 * Memory tile geometry
 * Widths, bank and macro layout, and the client operation codes
 */
`ifndef MEM_TILE_DEFS_SVH
`define MEM_TILE_DEFS_SVH

`define MEM_ADDR_W         10
`define MEM_DATA_W         64
`define MEM_STRB_W         8
`define MEM_BANKS_PER_WORD 2
`define MEM_BANK_ROWS      2
`define SRAM_DATA_W        32
`define SRAM_NUM_WORDS     64
`define SRAM_ADDR_W        6
`define SRAM_ADDR_OFFSET   3
`define MACRO_SEL_OFFSET   9
`define MACRO_SEL_W        1
`define MEM_OP_W           2

// Client operation codes
`define MEM_OP_READ     2'd0
`define MEM_OP_WRITE    2'd1
`define MEM_OP_AMO_ADD  2'd2
`define MEM_OP_AMO_SWAP 2'd3

`endif

// ==== src/mem_tile_pkg.sv ====
/*
 * Memory tile types
 * Vector types shared by the tile modules and the testbench
 */
`include "mem_tile_defs.svh"

package mem_tile_pkg;

  // Client side
  typedef logic [`MEM_ADDR_W-1:0] addr_t;
  typedef logic [`MEM_DATA_W-1:0] data_t;
  typedef logic [`MEM_STRB_W-1:0] strb_t;
  typedef logic [`MEM_OP_W-1:0]   op_t;

  // SRAM macro side
  typedef logic [`SRAM_ADDR_W-1:0]   sram_addr_t;
  typedef logic [`SRAM_DATA_W-1:0]   sram_data_t;
  typedef logic [`SRAM_DATA_W/8-1:0] sram_strb_t;

  // Index of the macro row within a bank
  typedef logic [`MACRO_SEL_W-1:0] macro_sel_t;

endpackage

// ==== src/mem_bus_if.sv ====
/*
 * Internal memory bus
 * Valid/ready request channel with a single-cycle read response
 */
`timescale 1ns/1ps

interface mem_bus_if;

  logic                req_valid;
  logic                req_ready;
  logic                req_we;
  mem_tile_pkg::addr_t req_addr;
  mem_tile_pkg::data_t req_wdata;
  mem_tile_pkg::strb_t req_be;
  logic                rsp_valid;
  mem_tile_pkg::data_t rsp_rdata;

  modport mgr (
    output req_valid, req_we, req_addr, req_wdata, req_be,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport sbr (
    input  req_valid, req_we, req_addr, req_wdata, req_be,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

// ==== src/mem_sram_macro.sv ====
/*
 * Single-port SRAM macro
 * Byte-enabled writes, registered read data
 */
`timescale 1ns/1ps
`include "mem_tile_defs.svh"

module mem_sram_macro (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  mem_tile_pkg::sram_addr_t addr_i,
  input  mem_tile_pkg::sram_data_t wdata_i,
  input  mem_tile_pkg::sram_strb_t be_i,
  output mem_tile_pkg::sram_data_t rdata_o
);

  mem_tile_pkg::sram_data_t mem_q [`SRAM_NUM_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < `SRAM_DATA_W/8; i++) begin
          if (be_i[i]) mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end else begin
        // Output holds until the next read
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== src/mem_sram_banks.sv ====
/*
 * Banked SRAM
 * Two 32-bit banks per word, two macro rows per bank picked by an address
 * bit, always ready, read data one cycle after accept
 */
`timescale 1ns/1ps
`include "mem_tile_defs.svh"

module mem_sram_banks (
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_bus_if.sbr bus_i
);

  mem_tile_pkg::sram_addr_t sram_addr;
  mem_tile_pkg::macro_sel_t macro_sel;
  mem_tile_pkg::macro_sel_t macro_sel_q;
  mem_tile_pkg::sram_data_t [`MEM_BANK_ROWS-1:0][`MEM_BANKS_PER_WORD-1:0] sram_rdata;
  logic                     rd_req;
  logic                     rsp_valid_q;

  assign bus_i.req_ready = 1'b1;

  assign sram_addr = bus_i.req_addr[`SRAM_ADDR_OFFSET +: `SRAM_ADDR_W];
  assign macro_sel = bus_i.req_addr[`MACRO_SEL_OFFSET +: `MACRO_SEL_W];
  assign rd_req    = bus_i.req_valid && !bus_i.req_we;

  // Remember which row answers the read in the next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      macro_sel_q <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_req;
      if (rd_req) macro_sel_q <= macro_sel;
    end
  end

  assign bus_i.rsp_valid = rsp_valid_q;

  ////////////////////////////////////////
  // Macros
  ////////////////////////////////////////

  for (genvar b = 0; b < `MEM_BANKS_PER_WORD; b++) begin : gen_banks
    assign bus_i.rsp_rdata[b*`SRAM_DATA_W +: `SRAM_DATA_W] = sram_rdata[macro_sel_q][b];

    for (genvar r = 0; r < `MEM_BANK_ROWS; r++) begin : gen_rows
      mem_sram_macro i_macro (
        .clk_i   (clk_i),
        .req_i   (bus_i.req_valid && (macro_sel == mem_tile_pkg::macro_sel_t'(r))),
        .we_i    (bus_i.req_we && (macro_sel == mem_tile_pkg::macro_sel_t'(r))),
        .addr_i  (sram_addr),
        .wdata_i (bus_i.req_wdata[b*`SRAM_DATA_W +: `SRAM_DATA_W]),
        .be_i    (bus_i.req_be[b*(`SRAM_DATA_W/8) +: `SRAM_DATA_W/8]),
        .rdata_o (sram_rdata[r][b])
      );
    end
  end

endmodule

// ==== src/mem_req_cut.sv ====
/*
 * Request register slice
 * One entry on the request path
 * Read response passes straight back
 */
`timescale 1ns/1ps

module mem_req_cut (
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_bus_if.sbr bus_i,
  mem_bus_if.mgr bus_o
);

  logic                full_q;
  logic                we_q;
  mem_tile_pkg::addr_t addr_q;
  mem_tile_pkg::data_t wdata_q;
  mem_tile_pkg::strb_t be_q;

  // Free when empty or when the held entry leaves this cycle
  assign bus_i.req_ready = !full_q || bus_o.req_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (bus_i.req_ready) begin
      full_q <= bus_i.req_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req_valid && bus_i.req_ready) begin
      we_q    <= bus_i.req_we;
      addr_q  <= bus_i.req_addr;
      wdata_q <= bus_i.req_wdata;
      be_q    <= bus_i.req_be;
    end
  end

  assign bus_o.req_valid = full_q;
  assign bus_o.req_we    = we_q;
  assign bus_o.req_addr  = addr_q;
  assign bus_o.req_wdata = wdata_q;
  assign bus_o.req_be    = be_q;

  // Response path
  assign bus_i.rsp_valid = bus_o.rsp_valid;
  assign bus_i.rsp_rdata = bus_o.rsp_rdata;

endmodule

// ==== src/mem_amo_frontend.sv ====
/*
 * Memory tile front end
 * Four-phase client handshake, and atomics split into a read
 * followed by a write of the new word
 */
`timescale 1ns/1ps
`include "mem_tile_defs.svh"

module mem_amo_frontend (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  output logic                ack_o,
  input  mem_tile_pkg::op_t   op_i,
  input  mem_tile_pkg::addr_t addr_i,
  input  mem_tile_pkg::data_t wdata_i,
  input  mem_tile_pkg::strb_t be_i,
  output mem_tile_pkg::data_t rdata_o,
  mem_bus_if.mgr              bus_o
);

  typedef enum logic [2:0] {
    IDLE,
    ISSUE,
    WAIT_RSP,
    AMO_WRITE,
    ACK
  } amo_state_e;

  amo_state_e          state_q;
  amo_state_e          state_d;
  mem_tile_pkg::op_t   op_q;
  mem_tile_pkg::addr_t addr_q;
  mem_tile_pkg::data_t wdata_q;
  mem_tile_pkg::strb_t be_q;
  mem_tile_pkg::data_t amo_word;
  logic                is_write;
  logic                is_amo;

  assign is_write = (op_q == `MEM_OP_WRITE);
  assign is_amo   = (op_q == `MEM_OP_AMO_ADD) || (op_q == `MEM_OP_AMO_SWAP);

  // New word of an atomic with a wrapping add
  assign amo_word = (op_q == `MEM_OP_AMO_ADD) ? bus_o.rsp_rdata + wdata_q : wdata_q;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i) state_d = ISSUE;
      end
      ISSUE: begin
        if (bus_o.req_ready) state_d = is_write ? ACK : WAIT_RSP;
      end
      WAIT_RSP: begin
        if (bus_o.rsp_valid) state_d = is_amo ? AMO_WRITE : ACK;
      end
      AMO_WRITE: begin
        if (bus_o.req_ready) state_d = ACK;
      end
      // Hold the acknowledge until the client lets go
      ACK: begin
        if (!req_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request capture and read data
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      op_q    <= op_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
    if (state_q == WAIT_RSP && bus_o.rsp_valid) begin
      rdata_o <= bus_o.rsp_rdata;
      wdata_q <= amo_word;
    end
  end

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////

  assign bus_o.req_valid = (state_q == ISSUE) || (state_q == AMO_WRITE);
  assign bus_o.req_we    = (state_q == AMO_WRITE) || (state_q == ISSUE && is_write);
  assign bus_o.req_addr  = addr_q;
  assign bus_o.req_wdata = wdata_q;
  assign bus_o.req_be    = (state_q == AMO_WRITE) ? {`MEM_STRB_W{1'b1}} : be_q;

  assign ack_o = (state_q == ACK);

endmodule

// ==== src/mem_tile.sv ====
/*
 * Memory tile
 * Client port with atomics in front of a request cut and a banked SRAM
 */
`timescale 1ns/1ps

module mem_tile (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  output logic                ack_o,
  input  mem_tile_pkg::op_t   op_i,
  input  mem_tile_pkg::addr_t addr_i,
  input  mem_tile_pkg::data_t wdata_i,
  input  mem_tile_pkg::strb_t be_i,
  output mem_tile_pkg::data_t rdata_o
);

  mem_bus_if bus_cut ();
  mem_bus_if bus_mem ();

  mem_amo_frontend i_frontend (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .ack_o   (ack_o),
    .op_i    (op_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .rdata_o (rdata_o),
    .bus_o   (bus_cut.mgr)
  );

  mem_req_cut i_cut (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus_i   (bus_cut.sbr),
    .bus_o   (bus_mem.mgr)
  );

  mem_sram_banks i_banks (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus_i   (bus_mem.sbr)
  );

endmodule

// ==== sim/tb_clk_gen.sv ====
/*
 * Testbench clock and reset
 * 100 ns clock, reset held low for the first 4 cycles
 */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== sim/tb_mem_tile.sv ====
/*
 * Memory tile testbench
 * Table of client operations run through the four-phase port and
 * checked against a reference memory model
 */
`timescale 1ns/1ps
`include "mem_tile_defs.svh"

module tb_mem_tile;

  localparam int REF_WORDS = 1 << (`MEM_ADDR_W - `SRAM_ADDR_OFFSET);

  logic                clk;
  logic                rst_n;
  logic                req;
  logic                ack;
  mem_tile_pkg::op_t   op;
  mem_tile_pkg::addr_t addr;
  mem_tile_pkg::data_t wdata;
  mem_tile_pkg::strb_t be;
  mem_tile_pkg::data_t rdata;

  // Stimulus table, one entry per client operation
  mem_tile_pkg::op_t   op_tab    [$];
  mem_tile_pkg::addr_t addr_tab  [$];
  mem_tile_pkg::data_t wdata_tab [$];
  mem_tile_pkg::strb_t be_tab    [$];
  int                  hold_tab  [$];
  mem_tile_pkg::data_t exp_tab   [$];

  mem_tile_pkg::data_t ref_mem [REF_WORDS];
  logic [31:0]         lfsr_q;
  logic                table_ready;
  int                  num_errors;
  int                  num_checks;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mem_tile i_dut (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .req_i   (req),
    .ack_o   (ack),
    .op_i    (op),
    .addr_i  (addr),
    .wdata_i (wdata),
    .be_i    (be),
    .rdata_o (rdata)
  );

  ////////////////////////////////////////
  // Random data and reference model
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic mem_tile_pkg::data_t random_word();
    mem_tile_pkg::data_t w;
    w = '0;
    for (int i = 0; i < `MEM_DATA_W; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[`MEM_DATA_W-2:0], lfsr_q[0]};
    end
    return w;
  endfunction

  // Expected read data is the word before the operation
  task automatic add_entry(input mem_tile_pkg::op_t o, input mem_tile_pkg::addr_t a,
                           input mem_tile_pkg::data_t d, input mem_tile_pkg::strb_t b,
                           input int hold);
    int                  w;
    mem_tile_pkg::data_t old;
    w   = a[`MEM_ADDR_W-1:`SRAM_ADDR_OFFSET];
    old = ref_mem[w];
    case (o)
      `MEM_OP_WRITE: begin
        for (int i = 0; i < `MEM_STRB_W; i++) begin
          if (b[i]) ref_mem[w][i*8 +: 8] = d[i*8 +: 8];
        end
      end
      `MEM_OP_AMO_ADD:  ref_mem[w] = old + d;
      `MEM_OP_AMO_SWAP: ref_mem[w] = d;
      default: ;
    endcase
    op_tab.push_back(o);
    addr_tab.push_back(a);
    wdata_tab.push_back(d);
    be_tab.push_back(b);
    hold_tab.push_back(hold);
    exp_tab.push_back(old);
  endtask

  task automatic build_table();
    // Full words in both rows, then partial enables
    add_entry(`MEM_OP_WRITE, 10'h008, random_word(), 8'hff, 0);
    add_entry(`MEM_OP_READ, 10'h008, '0, 8'h00, 0);
    add_entry(`MEM_OP_WRITE, 10'h3f8, random_word(), 8'hff, 0);
    add_entry(`MEM_OP_READ, 10'h3f8, '0, 8'h00, 0);
    add_entry(`MEM_OP_WRITE, 10'h008, random_word(), 8'h0f, 0);
    add_entry(`MEM_OP_READ, 10'h008, '0, 8'h00, 0);
    add_entry(`MEM_OP_WRITE, 10'h008, random_word(), 8'ha5, 0);
    add_entry(`MEM_OP_READ, 10'h008, '0, 8'h00, 0);
    add_entry(`MEM_OP_WRITE, 10'h3f8, random_word(), 8'hf0, 0);
    add_entry(`MEM_OP_READ, 10'h3f8, '0, 8'h00, 0);
    // Same macro address, other row
    add_entry(`MEM_OP_WRITE, 10'h040, random_word(), 8'hff, 0);
    add_entry(`MEM_OP_WRITE, 10'h240, random_word(), 8'hff, 0);
    add_entry(`MEM_OP_READ, 10'h040, '0, 8'h00, 0);
    add_entry(`MEM_OP_READ, 10'h240, '0, 8'h00, 0);
    // Atomics
    add_entry(`MEM_OP_AMO_ADD, 10'h040, random_word(), 8'h00, 0);
    add_entry(`MEM_OP_READ, 10'h040, '0, 8'h00, 0);
    add_entry(`MEM_OP_AMO_ADD, 10'h240, 64'hffff_ffff_ffff_fff0, 8'h00, 0);
    add_entry(`MEM_OP_READ, 10'h240, '0, 8'h00, 0);
    add_entry(`MEM_OP_AMO_SWAP, 10'h008, random_word(), 8'h00, 0);
    add_entry(`MEM_OP_READ, 10'h008, '0, 8'h00, 0);
    // Client holds req past the acknowledge
    add_entry(`MEM_OP_WRITE, 10'h100, random_word(), 8'hff, 3);
    add_entry(`MEM_OP_READ, 10'h100, '0, 8'h00, 2);
    // An add run twice would show in the read after it
    add_entry(`MEM_OP_AMO_ADD, 10'h100, random_word(), 8'h00, 3);
    add_entry(`MEM_OP_READ, 10'h100, '0, 8'h00, 0);
  endtask

  ////////////////////////////////////////
  // Four-phase client
  ////////////////////////////////////////

  task automatic run_entry(input int n);
    int errs;
    errs = num_errors;
    @(posedge clk);
    op    <= op_tab[n];
    addr  <= addr_tab[n];
    wdata <= wdata_tab[n];
    be    <= be_tab[n];
    req   <= 1'b1;
    @(negedge clk);
    while (ack !== 1'b1) @(negedge clk);
    if (op_tab[n] != `MEM_OP_WRITE) begin
      num_checks++;
      if (rdata !== exp_tab[n]) begin
        $display("[ERROR] rdata_o: got %h expected %h", rdata, exp_tab[n]);
        num_errors++;
      end
    end
    repeat (hold_tab[n]) begin
      @(negedge clk);
      num_checks++;
      if (ack !== 1'b1) begin
        $display("[ERROR] ack_o: got %h expected %h", ack, 1'b1);
        num_errors++;
      end
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    while (ack !== 1'b0) @(negedge clk);
    $display("test %0d op %0d addr %h: %s", n, op_tab[n], addr_tab[n],
             (num_errors == errs) ? "ok" : "failed");
  endtask

  initial begin
    req         = 1'b0;
    op          = '0;
    addr        = '0;
    wdata       = '0;
    be          = '0;
    lfsr_q      = 32'hb679_0f09;
    num_errors  = 0;
    num_checks  = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    wait (rst_n === 1'b1);
    // Port idle after reset
    repeat (2) @(negedge clk);
    num_checks++;
    if (ack !== 1'b0) begin
      $display("[ERROR] ack_o: got %h expected %h", ack, 1'b0);
      num_errors++;
    end
    $display("test reset: %s", (num_errors == 0) ? "ok" : "failed");
    for (int n = 0; n < op_tab.size(); n++) begin
      run_entry(n);
    end
    $display("tests %0d, checks %0d, errors %0d", op_tab.size() + 1, num_checks, num_errors);
    if (num_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (table_ready === 1'b1);
    repeat (op_tab.size() * 20) @(posedge clk);
    $display("Timeout: the DUT did not finish the table within %0d cycles",
             op_tab.size() * 20);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+src
src/mem_tile_pkg.sv
src/mem_bus_if.sv
src/mem_sram_macro.sv
src/mem_sram_banks.sv
src/mem_req_cut.sv
src/mem_amo_frontend.sv
src/mem_tile.sv
sim/tb_clk_gen.sv
sim/tb_mem_tile.sv

// ==== Bender.yml ====
package:
  name: mem_tile

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/mem_tile_pkg.sv
      - src/mem_bus_if.sv
      - src/mem_sram_macro.sv
      - src/mem_sram_banks.sv
      - src/mem_req_cut.sv
      - src/mem_amo_frontend.sv
      - src/mem_tile.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_mem_tile.sv
